// File: hw/arb_pkg.sv
// Grid arbiter shared definitions
package arb_pkg;

    // Grid dimensions
    localparam int GRID_ROWS = 8;                    // Requester rows
    localparam int GRID_COLS = 8;                    // Requester columns

    localparam int ROW_IDX_W = $clog2(GRID_ROWS);    // Row index width
    localparam int COL_IDX_W = $clog2(GRID_COLS);    // Column index width

    // Sequencer phases
    typedef enum logic [1:0] {
        PH_IDLE       = 2'b00,                       // Waiting for enable
        PH_ROW_SELECT = 2'b01,                       // Picking next row
        PH_COL_GRANT  = 2'b10                        // Granting cells of latched row
    } phase_t;

    // One granted cell as one-hot vectors and as indices
    typedef struct packed {
        logic                 valid;                 // Grant strobe this cycle
        logic [GRID_ROWS-1:0] row_gnt;               // One-hot row
        logic [GRID_COLS-1:0] col_gnt;               // One-hot column
        logic [ROW_IDX_W-1:0] row_idx;               // Row index
        logic [COL_IDX_W-1:0] col_idx;               // Column index
    } cell_grant_t;

endpackage

// File: hw/rr_arbiter.sv
// Round-robin arbiter
`timescale 1ns/100ps

module rr_arbiter #(
    parameter int WIDTH = 8,                                  // Number of requesters
    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1   // Index width
) (
    input  logic             clk_i,       // Clock
    input  logic             reset_i,     // Async reset, active high
    input  logic [WIDTH-1:0] req_i,       // Request levels
    input  logic             take_i,      // Grant used, rotate pointer
    output logic [WIDTH-1:0] gnt_o,       // One-hot grant
    output logic [IDX_W-1:0] idx_o,       // Index of granted requester
    output logic             any_o        // Some request present
);

    logic [IDX_W-1:0] ptr_q;              // Highest-priority position
    logic [IDX_W-1:0] ptr_next;           // Position after current grant
    logic             found;              // Search already hit

    assign any_o = |req_i;                // Grant exists iff any request

    // Scan from the pointer upward, wrapping at WIDTH
    always_comb begin
        int cand;                         // Candidate position
        gnt_o = '0;
        idx_o = '0;
        found = 1'b0;
        for (int off = 0; off < WIDTH; off++) begin
            cand = (int'(ptr_q) + off) % WIDTH;   // Wrapped position
            if (!found && req_i[cand]) begin
                gnt_o[cand] = 1'b1;               // First hit wins
                idx_o       = IDX_W'(cand);
                found       = 1'b1;
            end
        end
    end

    // Pointer moves one past the winner, modulo WIDTH
    always_comb begin
        if (idx_o == IDX_W'(WIDTH - 1)) begin
            ptr_next = '0;                        // Wrap to start
        end else begin
            ptr_next = idx_o + 1'b1;
        end
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            ptr_q <= '0;                          // Position 0 first after reset
        end else if (take_i) begin
            ptr_q <= ptr_next;                    // Rotate only when grant taken
        end
    end

    // Grant is one-hot or empty
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o));

    // Grant only goes to a requester
    a_gnt_in_req: assert property (@(posedge clk_i) disable iff (reset_i)
        (gnt_o & ~req_i) == '0);

    // Sequencer never consumes an empty grant
    a_take_needs_any: assert property (@(posedge clk_i) disable iff (reset_i)
        take_i |-> any_o);

endmodule

// File: hw/grid_sequencer.sv
// Grid arbiter phase sequencer
`timescale 1ns/100ps

module grid_sequencer
    import arb_pkg::*;
(
    input  logic                                 clk_i,       // Clock
    input  logic                                 reset_i,     // Async reset, active high
    input  logic                                 enable_i,    // Arbitration enable level
    input  logic [GRID_ROWS-1:0][GRID_COLS-1:0]  req_i,       // Request matrix, row then column
    input  logic [GRID_ROWS-1:0]                 row_gnt_i,   // Row arbiter one-hot grant
    input  logic [ROW_IDX_W-1:0]                 row_idx_i,   // Row arbiter grant index
    input  logic                                 row_any_i,   // Some row requests
    input  logic [GRID_COLS-1:0]                 col_gnt_i,   // Column arbiter one-hot grant
    input  logic [COL_IDX_W-1:0]                 col_idx_i,   // Column arbiter grant index
    input  logic                                 col_any_i,   // Unserved column pending
    output logic [GRID_ROWS-1:0]                 row_req_o,   // Per-row request reduction
    output logic                                 row_take_o,  // Row latched this cycle
    output logic [GRID_COLS-1:0]                 col_req_o,   // Unserved requests of latched row
    output logic                                 col_take_o,  // Column granted this cycle
    output cell_grant_t                          grant_o      // Cell grant to top level
);

    phase_t               phase_q;        // Current phase
    phase_t               phase_d;        // Next phase
    logic [ROW_IDX_W-1:0] row_q;          // Latched row index
    logic [GRID_ROWS-1:0] row_oh_q;       // Latched row, one-hot
    logic [GRID_COLS-1:0] served_q;       // Columns already granted in this visit
    logic [GRID_COLS-1:0] live_cols;      // Latched row requests not yet served
    logic [GRID_COLS-1:0] left_cols;      // Still unserved after this cycle's grant

    // OR of each row feeds the row arbiter
    always_comb begin
        for (int r = 0; r < GRID_ROWS; r++) begin
            row_req_o[r] = |req_i[r];
        end
    end

    // Column requests only during a visit, minus served columns
    assign live_cols = req_i[row_q] & ~served_q;
    assign col_req_o = (phase_q == PH_COL_GRANT) ? live_cols : '0;
    assign left_cols = col_req_o & ~col_gnt_i;    // Work remaining after current grant

    // Phase transitions and take strobes
    always_comb begin
        phase_d    = phase_q;
        row_take_o = 1'b0;
        col_take_o = 1'b0;
        case (phase_q)
            PH_IDLE: begin
                if (enable_i) begin
                    phase_d = PH_ROW_SELECT;      // Start arbitrating
                end
            end

            PH_ROW_SELECT: begin
                // Enable sampled only here, between visits
                if (!enable_i) begin
                    phase_d = PH_IDLE;
                end else if (row_any_i) begin
                    row_take_o = 1'b1;            // Latch winner, rotate row pointer
                    phase_d    = PH_COL_GRANT;
                end
            end

            PH_COL_GRANT: begin
                if (col_any_i) begin
                    col_take_o = 1'b1;            // Grant one cell this cycle
                    if (left_cols == '0) begin
                        phase_d = PH_ROW_SELECT;  // Last cell of the visit
                    end
                end else begin
                    phase_d = PH_ROW_SELECT;      // Requests dropped, end visit
                end
            end

            default: begin
                phase_d = PH_IDLE;                // Recover from illegal encoding
            end
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            phase_q  <= PH_IDLE;
            row_q    <= '0;
            row_oh_q <= '0;
            served_q <= '0;
        end else begin
            phase_q <= phase_d;
            if (row_take_o) begin
                row_q    <= row_idx_i;            // New visit
                row_oh_q <= row_gnt_i;
                served_q <= '0;                   // Fresh mask per visit
            end else if (col_take_o) begin
                served_q <= served_q | col_gnt_i; // Each column once per visit
            end
        end
    end

    // Grant fields, valid only on a column take
    always_comb begin
        grant_o.valid   = col_take_o;
        grant_o.row_gnt = row_oh_q;
        grant_o.col_gnt = col_gnt_i;
        grant_o.row_idx = row_q;
        grant_o.col_idx = col_idx_i;
    end

    // A granted cell is requested in the live matrix
    a_grant_requested: assert property (@(posedge clk_i) disable iff (reset_i)
        grant_o.valid |-> req_i[grant_o.row_idx][grant_o.col_idx]);

    // Column takes happen only inside a visit
    a_take_in_visit: assert property (@(posedge clk_i) disable iff (reset_i)
        col_take_o |-> (phase_q == PH_COL_GRANT));

    // Phase register holds a legal encoding
    a_phase_legal: assert property (@(posedge clk_i) disable iff (reset_i)
        phase_q inside {PH_IDLE, PH_ROW_SELECT, PH_COL_GRANT});

endmodule

// File: hw/grid_arb_top.sv
// Two-level grid arbiter
`timescale 1ns/100ps

module grid_arb_top
    import arb_pkg::*;
(
    input  logic                                clk_i,      // Clock
    input  logic                                reset_i,    // Async reset, active high
    input  logic [GRID_ROWS-1:0][GRID_COLS-1:0] req_i,      // Request matrix, row then column
    input  logic                                enable_i,   // Arbitration enable level
    output logic [GRID_ROWS-1:0]                x_gnt_o,    // One-hot row grant strobe
    output logic [GRID_COLS-1:0]                y_gnt_o     // One-hot column grant strobe
);

    logic [GRID_ROWS-1:0] row_req;        // Row reductions
    logic [GRID_ROWS-1:0] row_gnt;        // Row arbiter grant
    logic [ROW_IDX_W-1:0] row_idx;        // Row arbiter index
    logic                 row_any;        // Some row requests
    logic                 row_take;       // Row latched
    logic [GRID_COLS-1:0] col_req;        // Masked column requests
    logic [GRID_COLS-1:0] col_gnt;        // Column arbiter grant
    logic [COL_IDX_W-1:0] col_idx;        // Column arbiter index
    logic                 col_any;        // Unserved column pending
    logic                 col_take;       // Column granted
    cell_grant_t          grant;          // Assembled cell grant

    rr_arbiter #(.WIDTH(GRID_ROWS)) u_row_arb (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (row_req),
        .take_i  (row_take),
        .gnt_o   (row_gnt),
        .idx_o   (row_idx),
        .any_o   (row_any)
    );

    rr_arbiter #(.WIDTH(GRID_COLS)) u_col_arb (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (col_req),
        .take_i  (col_take),
        .gnt_o   (col_gnt),
        .idx_o   (col_idx),
        .any_o   (col_any)
    );

    grid_sequencer u_sequencer (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .enable_i   (enable_i),
        .req_i      (req_i),
        .row_gnt_i  (row_gnt),
        .row_idx_i  (row_idx),
        .row_any_i  (row_any),
        .col_gnt_i  (col_gnt),
        .col_idx_i  (col_idx),
        .col_any_i  (col_any),
        .row_req_o  (row_req),
        .row_take_o (row_take),
        .col_req_o  (col_req),
        .col_take_o (col_take),
        .grant_o    (grant)
    );

    // Outputs are quiet outside a grant cycle
    assign x_gnt_o = grant.valid ? grant.row_gnt : '0;
    assign y_gnt_o = grant.valid ? grant.col_gnt : '0;

endmodule

// File: verif/grid_ref_model.svh
// Grid arbiter reference model
`ifndef GRID_REF_MODEL_SVH
`define GRID_REF_MODEL_SVH

phase_t               m_phase;      // Predicted phase
int                   m_row_ptr;    // Row round-robin pointer
int                   m_col_ptr;    // Column round-robin pointer
int                   m_row;        // Row under visit
logic [GRID_COLS-1:0] m_served;     // Columns granted in this visit

// First set bit at or after ptr, wrapping; -1 when none
function automatic int first_from(input logic [31:0] vec, input int ptr, input int width);
    int pos;
    for (int n = 0; n < width; n++) begin
        pos = (ptr + n) % width;
        if (vec[pos]) begin
            return pos;
        end
    end
    return -1;
endfunction

task automatic model_reset();
    m_phase   = PH_IDLE;
    m_row_ptr = 0;
    m_col_ptr = 0;
    m_row     = 0;
    m_served  = '0;
endtask

// Outputs of the current cycle, then the state after the next rising edge
task automatic model_cycle(
    input  logic [GRID_ROWS-1:0][GRID_COLS-1:0] req,
    input  logic                                en,
    output logic [GRID_ROWS-1:0]                exp_x,
    output logic [GRID_COLS-1:0]                exp_y
);
    logic [GRID_ROWS-1:0] busy_rows;    // Rows with any request
    logic [GRID_COLS-1:0] pending;      // Unserved columns of visited row
    int                   pick;
    exp_x = '0;
    exp_y = '0;
    for (int r = 0; r < GRID_ROWS; r++) begin
        busy_rows[r] = |req[r];
    end
    case (m_phase)
        PH_IDLE: begin
            if (en) begin
                m_phase = PH_ROW_SELECT;
            end
        end
        PH_ROW_SELECT: begin
            pick = first_from(32'(busy_rows), m_row_ptr, GRID_ROWS);
            if (!en) begin
                m_phase = PH_IDLE;                  // Enable only matters here
            end else if (pick >= 0) begin
                m_row     = pick;
                m_row_ptr = (pick + 1) % GRID_ROWS;
                m_served  = '0;                     // New visit
                m_phase   = PH_COL_GRANT;
            end
        end
        PH_COL_GRANT: begin
            pending = req[m_row] & ~m_served;
            pick    = first_from(32'(pending), m_col_ptr, GRID_COLS);
            if (pick < 0) begin
                m_phase = PH_ROW_SELECT;            // Requests dropped away
            end else begin
                exp_x[m_row]   = 1'b1;
                exp_y[pick]    = 1'b1;
                m_served[pick] = 1'b1;
                m_col_ptr      = (pick + 1) % GRID_COLS;
                if ((pending & ~exp_y) == '0) begin
                    m_phase = PH_ROW_SELECT;        // Row done
                end
            end
        end
        default: begin
            m_phase = PH_IDLE;
        end
    endcase
endtask

`endif

// File: verif/tb_grid_arb.sv
// Grid arbiter testbench
`timescale 1ns/100ps

module tb_grid_arb
    import arb_pkg::*;
();

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 3;
    localparam int WATCHDOG_MARGIN = 50;    // Slack beyond the table length

    // One table row
    typedef struct packed {
        logic [GRID_ROWS-1:0][GRID_COLS-1:0] req;     // Matrix, row 7 in top byte
        logic                                en;      // Enable level
        logic                                rnd;     // Draw a random matrix instead
        logic [7:0]                          cycles;  // Cycles to hold the entry
    } stim_t;

    logic                                clk_i;
    logic                                reset_i;
    logic                                enable_i;
    logic [GRID_ROWS-1:0][GRID_COLS-1:0] req_i;
    logic [GRID_ROWS-1:0]                x_gnt_o;
    logic [GRID_COLS-1:0]                y_gnt_o;

    stim_t  stim_q[$];                      // Stimulus table
    int     total_cycles;                   // Sum of table cycle counts
    logic   table_ready;
    int     errors;
    int     checks;
    integer seed;

    `include "grid_ref_model.svh"

    grid_arb_top u_grid_arb_top (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .enable_i (enable_i),
        .x_gnt_o  (x_gnt_o),
        .y_gnt_o  (y_gnt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic add_entry(input logic [63:0] req, input logic en, input logic rnd,
                             input int cycles);
        stim_q.push_back('{req: req, en: en, rnd: rnd, cycles: 8'(cycles)});
        total_cycles += cycles;
    endtask

    task automatic build_table();
        add_entry(64'h0000_0000_0000_0000, 1'b0, 1'b0, 6);   // Idle, disabled
        add_entry(64'h0000_0000_0020_0000, 1'b0, 1'b0, 5);   // Request, still disabled
        add_entry(64'h0000_0000_0020_0000, 1'b1, 1'b0, 12);  // Single cell, row 2 col 5
        add_entry(64'h0000_0000_0000_0000, 1'b1, 1'b0, 5);   // Enabled, empty matrix
        add_entry(64'h0000_00B5_0000_0000, 1'b1, 1'b0, 14);  // Row 4, five columns
        add_entry(64'h8100_4200_0018_0003, 1'b1, 1'b0, 30);  // Four rows compete
        add_entry(64'h8100_4200_0018_0003, 1'b0, 1'b0, 8);   // Enable drops
        add_entry(64'h8100_4200_0018_0003, 1'b1, 1'b0, 12);  // Resume after last row
        add_entry(64'h0, 1'b1, 1'b1, 20);
        add_entry(64'h0, 1'b1, 1'b1, 5);                     // Short ones drop requests mid-visit
        add_entry(64'h0, 1'b1, 1'b1, 3);
        add_entry(64'h0, 1'b0, 1'b1, 3);
        add_entry(64'h0, 1'b1, 1'b1, 7);
        add_entry(64'h0, 1'b1, 1'b1, 25);
    endtask

    // True when the granted row and column hold a request
    function automatic logic cell_requested(input logic [GRID_ROWS-1:0][GRID_COLS-1:0] req,
                                            input logic [GRID_ROWS-1:0] x,
                                            input logic [GRID_COLS-1:0] y);
        logic hit;
        hit = 1'b0;
        for (int r = 0; r < GRID_ROWS; r++) begin
            if (x[r] && (req[r] & y) != '0) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic check_outputs(input logic [GRID_ROWS-1:0] exp_x,
                                 input logic [GRID_COLS-1:0] exp_y);
        checks++;
        if (x_gnt_o !== exp_x) begin
            errors++;
            $display("FAIL x_gnt_o expected %h actual %h at %0t", exp_x, x_gnt_o, $time);
        end
        if (y_gnt_o !== exp_y) begin
            errors++;
            $display("FAIL y_gnt_o expected %h actual %h at %0t", exp_y, y_gnt_o, $time);
        end
        if (x_gnt_o != '0 || y_gnt_o != '0) begin     // Grant cycle
            if (!$onehot(x_gnt_o)) begin
                errors++;
                $display("FAIL x_gnt_o not one-hot, actual %h at %0t", x_gnt_o, $time);
            end
            if (!$onehot(y_gnt_o)) begin
                errors++;
                $display("FAIL y_gnt_o not one-hot, actual %h at %0t", y_gnt_o, $time);
            end
            if (!cell_requested(req_i, x_gnt_o, y_gnt_o)) begin
                errors++;
                $display("Grant went to a cell with no request at %0t", $time);
            end
        end
    endtask

    initial begin
        logic [GRID_ROWS-1:0][GRID_COLS-1:0] cur_req;
        logic [GRID_ROWS-1:0]                exp_x;
        logic [GRID_COLS-1:0]                exp_y;
        reset_i      = 1'b1;
        enable_i     = 1'b0;
        req_i        = '0;
        errors       = 0;
        checks       = 0;
        seed         = 68;
        total_cycles = 0;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        foreach (stim_q[i]) begin
            if (stim_q[i].rnd) begin
                cur_req = {$random(seed), $random(seed)};
            end else begin
                cur_req = stim_q[i].req;
            end
            repeat (stim_q[i].cycles) begin
                req_i    = cur_req;                 // Falling edge drive
                enable_i = stim_q[i].en;
                #(CLK_PERIOD / 2 - 1);              // Just before rising edge
                model_cycle(req_i, enable_i, exp_x, exp_y);
                check_outputs(exp_x, exp_y);
                @(negedge clk_i);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Bounded by table length plus slack
    initial begin
        wait (table_ready === 1'b1);
        repeat (RESET_CYCLES + total_cycles + WATCHDOG_MARGIN) @(posedge clk_i);
        $display("Watchdog expired, the run did not finish in time (errors: %0d)", errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verif
hw/arb_pkg.sv
hw/rr_arbiter.sv
hw/grid_sequencer.sv
hw/grid_arb_top.sv
verif/tb_grid_arb.sv

// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_grid_arb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
